//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    typedef logic [WORD_W-1:0]   word_t;     // Data or instruction word
    typedef logic [REG_W-1:0]    reg_addr_t; // Register number
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT_W-1:0]  funct_t;
    typedef logic [IMM_W-1:0]    imm_t;      // Raw immediate field

    // Primary opcodes, bits 31:26
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_HALT  = 6'h3f;

    // R-type funct codes, bits 5:0
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT, // Signed compare
        ALU_LUI  // Immediate into upper half
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALTED
    } run_state_e;

    typedef enum logic {
        B_REG, // Second operand from rt
        B_IMM  // Second operand from extended immediate
    } b_src_e;

    typedef enum logic {
        DST_RD, // R-type destination
        DST_RT  // I-type destination
    } dst_sel_e;

endpackage

//--- hdl/mips_control.sv
`timescale 1ns/1ps

module mips_control (
    input  logic               clk_to_use,
    input  logic               i_rst,
    input  logic               i_start,
    input  isa_pkg::word_t     i_instr,
    input  isa_pkg::word_t     i_pc_next,
    input  logic               i_br_taken,
    input  isa_pkg::word_t     i_br_target,
    input  logic               i_ex_halt,
    output logic               o_fetch_en,
    output logic               o_pc_clear,
    output logic               o_redirect,
    output isa_pkg::word_t     o_redirect_pc,
    output logic               o_flush_ifid,
    output logic               o_flush_idex,
    output ctrl_pkg::alu_op_e  o_alu_op,
    output ctrl_pkg::b_src_e   o_b_src,
    output logic               o_imm_zero,
    output logic               o_reg_write,
    output isa_pkg::reg_addr_t o_dest,
    output logic               o_is_beq,
    output logic               o_is_bne,
    output logic               o_is_halt,
    output logic               o_id_valid,
    output logic               o_halted
);

    ctrl_pkg::run_state_e state;
    ctrl_pkg::dst_sel_e   dst_sel;
    isa_pkg::opcode_t     opcode;
    isa_pkg::funct_t      funct;
    logic                 is_j;
    logic                 running;
    logic                 start_ok;
    logic                 br_take;
    logic                 j_take;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            state <= ctrl_pkg::IDLE;
        end else if (start_ok) begin
            state <= ctrl_pkg::RUN;
        end else if (running && i_ex_halt) begin
            state <= ctrl_pkg::HALTED; // Older slots already retired
        end
    end

    assign running  = (state == ctrl_pkg::RUN);
    assign start_ok = i_start && !running;
    assign o_halted = (state == ctrl_pkg::HALTED);

    // Unknown codes fall through as no-ops
    always_comb begin
        o_alu_op    = ctrl_pkg::ALU_ADD;
        o_b_src     = ctrl_pkg::B_REG;
        o_imm_zero  = 1'b0;
        o_reg_write = 1'b0;
        dst_sel     = ctrl_pkg::DST_RD;
        o_is_beq    = 1'b0;
        o_is_bne    = 1'b0;
        o_is_halt   = 1'b0;
        is_j        = 1'b0;
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                o_reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: o_alu_op = ctrl_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: o_alu_op = ctrl_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  o_alu_op = ctrl_pkg::ALU_AND;
                    isa_pkg::FN_OR:   o_alu_op = ctrl_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  o_alu_op = ctrl_pkg::ALU_SLT;
                    default:          o_reg_write = 1'b0; // Also the all-zero NOP
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                o_b_src     = ctrl_pkg::B_IMM;
                o_reg_write = 1'b1;
                dst_sel     = ctrl_pkg::DST_RT;
            end
            isa_pkg::OP_ORI: begin
                o_alu_op    = ctrl_pkg::ALU_OR;
                o_b_src     = ctrl_pkg::B_IMM;
                o_imm_zero  = 1'b1;
                o_reg_write = 1'b1;
                dst_sel     = ctrl_pkg::DST_RT;
            end
            isa_pkg::OP_LUI: begin
                o_alu_op    = ctrl_pkg::ALU_LUI;
                o_reg_write = 1'b1;
                dst_sel     = ctrl_pkg::DST_RT;
            end
            isa_pkg::OP_BEQ:  o_is_beq  = 1'b1;
            isa_pkg::OP_BNE:  o_is_bne  = 1'b1;
            isa_pkg::OP_J:    is_j      = 1'b1;
            isa_pkg::OP_HALT: o_is_halt = 1'b1;
            default: ;
        endcase
    end

    assign o_dest     = (dst_sel == ctrl_pkg::DST_RT) ? i_instr[20:16] : i_instr[15:11];
    assign o_id_valid = running;

    // Branch in execute wins over J in decode
    assign br_take = running && i_br_taken;
    assign j_take  = running && is_j && !i_br_taken && !i_ex_halt;

    assign o_fetch_en    = running && !i_ex_halt;
    assign o_pc_clear    = start_ok;
    assign o_redirect    = br_take || j_take;
    assign o_redirect_pc = br_take ? i_br_target : {i_pc_next[31:26], i_instr[25:0]};
    assign o_flush_ifid  = o_redirect || (running && i_ex_halt);
    assign o_flush_idex  = br_take || (running && i_ex_halt) || start_ok;

    a_redirect_in_run: assert property (
        @(posedge clk_to_use) disable iff (i_rst) o_redirect |-> running
    );

endmodule

//--- hdl/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic           clk_to_use,
    input  logic           i_rst,
    input  logic           i_imem_we,
    input  isa_pkg::word_t i_imem_addr,
    input  isa_pkg::word_t i_imem_data,
    input  logic           i_fetch_en,
    input  logic           i_pc_clear,
    input  logic           i_redirect,
    input  isa_pkg::word_t i_redirect_pc,
    input  logic           i_flush,
    output isa_pkg::word_t o_instr,
    output isa_pkg::word_t o_pc_next
);

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    isa_pkg::word_t imem [IMEM_DEPTH];
    isa_pkg::word_t pc;       // Word address
    isa_pkg::word_t pc_plus1;

    assign pc_plus1 = pc + 32'd1;

    always_ff @(posedge clk_to_use) begin
        if (i_imem_we && !i_fetch_en) begin
            imem[i_imem_addr[ADDR_W-1:0]] <= i_imem_data; // Only while core is parked
        end
    end

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            pc      <= '0;
            o_instr <= '0;
        end else if (i_pc_clear) begin
            pc      <= '0;
            o_instr <= '0;
        end else if (i_fetch_en) begin
            pc      <= i_redirect ? i_redirect_pc : pc_plus1;
            o_instr <= i_flush ? '0 : imem[pc[ADDR_W-1:0]]; // Flush inserts NOP
        end else if (i_flush) begin
            o_instr <= '0;
        end
    end

    always_ff @(posedge clk_to_use) begin
        if (i_fetch_en) begin
            o_pc_next <= pc_plus1;
        end
    end

    a_no_load_in_run: assert property (
        @(posedge clk_to_use) disable iff (i_rst) i_fetch_en |-> !i_imem_we
    );

endmodule

//--- hdl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk_to_use,
    input  logic               i_rst,
    input  isa_pkg::reg_addr_t i_rs,
    input  isa_pkg::reg_addr_t i_rt,
    input  logic               i_we,
    input  isa_pkg::reg_addr_t i_wa,
    input  isa_pkg::word_t     i_wd,
    input  isa_pkg::reg_addr_t i_dbg_addr,
    output isa_pkg::word_t     o_rs_data,
    output isa_pkg::word_t     o_rt_data,
    output isa_pkg::word_t     o_dbg_data
);

    isa_pkg::word_t regs [1:31]; // No storage for r0

    // r0 reads zero and a same-cycle write passes straight through
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_we && (i_wa == addr)) begin
            return i_wd;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin
            regs[i_wa] <= i_wd;
        end
    end

    always_comb begin
        o_rs_data  = read_port(i_rs);
        o_rt_data  = read_port(i_rt);
        o_dbg_data = read_port(i_dbg_addr);
    end

    a_r0_zero: assert property (
        @(posedge clk_to_use) disable iff (i_rst) (i_rs == '0) |-> (o_rs_data == '0)
    );

endmodule

//--- hdl/mips_execute.sv
`timescale 1ns/1ps

module mips_execute (
    input  logic               clk_to_use,
    input  logic               i_rst,
    input  logic               i_flush,
    input  logic               i_id_valid,
    input  ctrl_pkg::alu_op_e  i_alu_op,
    input  ctrl_pkg::b_src_e   i_b_src,
    input  logic               i_imm_zero,
    input  logic               i_reg_write,
    input  isa_pkg::reg_addr_t i_dest,
    input  logic               i_is_beq,
    input  logic               i_is_bne,
    input  logic               i_is_halt,
    input  isa_pkg::reg_addr_t i_rs_addr,
    input  isa_pkg::reg_addr_t i_rt_addr,
    input  isa_pkg::word_t     i_rs_data,
    input  isa_pkg::word_t     i_rt_data,
    input  isa_pkg::imm_t      i_imm16,
    input  isa_pkg::word_t     i_pc_next,
    output logic               o_br_taken,
    output isa_pkg::word_t     o_br_target,
    output logic               o_ex_halt,
    output logic               o_wb_valid,
    output isa_pkg::reg_addr_t o_wb_reg,
    output isa_pkg::word_t     o_wb_data
);

    logic               ex_valid;
    ctrl_pkg::alu_op_e  ex_alu_op;
    ctrl_pkg::b_src_e   ex_b_src;
    logic               ex_imm_zero;
    logic               ex_reg_write;
    isa_pkg::reg_addr_t ex_dest;
    logic               ex_is_beq;
    logic               ex_is_bne;
    logic               ex_is_halt;
    isa_pkg::reg_addr_t ex_rs_addr;
    isa_pkg::reg_addr_t ex_rt_addr;
    isa_pkg::word_t     ex_rs_data;
    isa_pkg::word_t     ex_rt_data;
    isa_pkg::imm_t      ex_imm;
    isa_pkg::word_t     ex_pc_next;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     rt_fwd;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     imm_sext;
    isa_pkg::word_t     imm_ext;
    isa_pkg::word_t     alu_res;
    logic               ops_equal;

    // Decode/execute slot
    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= i_id_valid && !i_flush;
        end
    end

    always_ff @(posedge clk_to_use) begin
        ex_alu_op    <= i_alu_op;
        ex_b_src     <= i_b_src;
        ex_imm_zero  <= i_imm_zero;
        ex_reg_write <= i_reg_write;
        ex_dest      <= i_dest;
        ex_is_beq    <= i_is_beq;
        ex_is_bne    <= i_is_bne;
        ex_is_halt   <= i_is_halt;
        ex_rs_addr   <= i_rs_addr;
        ex_rt_addr   <= i_rt_addr;
        ex_rs_data   <= i_rs_data;
        ex_rt_data   <= i_rt_data;
        ex_imm       <= i_imm16;
        ex_pc_next   <= i_pc_next;
    end

    // Bypass from the writeback slot, whose valid already excludes r0
    assign op_a   = (o_wb_valid && o_wb_reg == ex_rs_addr) ? o_wb_data : ex_rs_data;
    assign rt_fwd = (o_wb_valid && o_wb_reg == ex_rt_addr) ? o_wb_data : ex_rt_data;

    assign imm_sext = {{16{ex_imm[15]}}, ex_imm};
    assign imm_ext  = ex_imm_zero ? {16'h0000, ex_imm} : imm_sext;
    assign op_b     = (ex_b_src == ctrl_pkg::B_IMM) ? imm_ext : rt_fwd;

    always_comb begin
        case (ex_alu_op)
            ctrl_pkg::ALU_ADD: alu_res = op_a + op_b;
            ctrl_pkg::ALU_SUB: alu_res = op_a - op_b;
            ctrl_pkg::ALU_AND: alu_res = op_a & op_b;
            ctrl_pkg::ALU_OR:  alu_res = op_a | op_b;
            ctrl_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ctrl_pkg::ALU_LUI: alu_res = {ex_imm, 16'h0000};
            default:           alu_res = '0;
        endcase
    end

    assign ops_equal   = (op_a == rt_fwd);
    assign o_br_taken  = ex_valid && ((ex_is_beq && ops_equal) || (ex_is_bne && !ops_equal));
    assign o_br_target = ex_pc_next + imm_sext; // Word offset from PC+1
    assign o_ex_halt   = ex_valid && ex_is_halt;

    // Execute/writeback slot
    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= ex_valid && ex_reg_write && (ex_dest != '0);
        end
    end

    always_ff @(posedge clk_to_use) begin
        o_wb_reg  <= ex_dest;
        o_wb_data <= alu_res;
    end

    a_no_r0_report: assert property (
        @(posedge clk_to_use) disable iff (i_rst) o_wb_valid |-> (o_wb_reg != '0)
    );

endmodule

//--- hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic               clk_to_use,
    input  logic               i_rst,
    input  logic               i_imem_we,
    input  isa_pkg::word_t     i_imem_addr,
    input  isa_pkg::word_t     i_imem_data,
    input  logic               i_start,
    input  isa_pkg::reg_addr_t i_dbg_addr,
    output logic               o_wb_valid,
    output isa_pkg::reg_addr_t o_wb_reg,
    output isa_pkg::word_t     o_wb_data,
    output logic               o_halted,
    output isa_pkg::word_t     o_dbg_data
);

    logic               fetch_en;
    logic               pc_clear;
    logic               redirect;
    isa_pkg::word_t     redirect_pc;
    logic               flush_ifid;
    logic               flush_idex;
    isa_pkg::word_t     instr;     // Fetch/decode register
    isa_pkg::word_t     pc_next;
    ctrl_pkg::alu_op_e  alu_op;
    ctrl_pkg::b_src_e   b_src;
    logic               imm_zero;
    logic               reg_write;
    isa_pkg::reg_addr_t dest;
    logic               is_beq;
    logic               is_bne;
    logic               is_halt;
    logic               id_valid;
    logic               br_taken;
    isa_pkg::word_t     br_target;
    logic               ex_halt;
    isa_pkg::word_t     rs_data;
    isa_pkg::word_t     rt_data;

    mips_control u_control (
        .clk_to_use    (clk_to_use),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_instr       (instr),
        .i_pc_next     (pc_next),
        .i_br_taken    (br_taken),
        .i_br_target   (br_target),
        .i_ex_halt     (ex_halt),
        .o_fetch_en    (fetch_en),
        .o_pc_clear    (pc_clear),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_flush_ifid  (flush_ifid),
        .o_flush_idex  (flush_idex),
        .o_alu_op      (alu_op),
        .o_b_src       (b_src),
        .o_imm_zero    (imm_zero),
        .o_reg_write   (reg_write),
        .o_dest        (dest),
        .o_is_beq      (is_beq),
        .o_is_bne      (is_bne),
        .o_is_halt     (is_halt),
        .o_id_valid    (id_valid),
        .o_halted      (o_halted)
    );

    mips_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk_to_use    (clk_to_use),
        .i_rst         (i_rst),
        .i_imem_we     (i_imem_we),
        .i_imem_addr   (i_imem_addr),
        .i_imem_data   (i_imem_data),
        .i_fetch_en    (fetch_en),
        .i_pc_clear    (pc_clear),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_flush       (flush_ifid),
        .o_instr       (instr),
        .o_pc_next     (pc_next)
    );

    mips_regfile u_regfile (
        .clk_to_use (clk_to_use),
        .i_rst      (i_rst),
        .i_rs       (instr[25:21]),
        .i_rt       (instr[20:16]),
        .i_we       (o_wb_valid),
        .i_wa       (o_wb_reg),
        .i_wd       (o_wb_data),
        .i_dbg_addr (i_dbg_addr),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    mips_execute u_execute (
        .clk_to_use  (clk_to_use),
        .i_rst       (i_rst),
        .i_flush     (flush_idex),
        .i_id_valid  (id_valid),
        .i_alu_op    (alu_op),
        .i_b_src     (b_src),
        .i_imm_zero  (imm_zero),
        .i_reg_write (reg_write),
        .i_dest      (dest),
        .i_is_beq    (is_beq),
        .i_is_bne    (is_bne),
        .i_is_halt   (is_halt),
        .i_rs_addr   (instr[25:21]),
        .i_rt_addr   (instr[20:16]),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .i_imm16     (instr[15:0]),
        .i_pc_next   (pc_next),
        .o_br_taken  (br_taken),
        .o_br_target (br_target),
        .o_ex_halt   (ex_halt),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data)
    );

endmodule

//--- testbench/tb_mips_asm.svh
function automatic isa_pkg::word_t enc_r(isa_pkg::funct_t fn, int rd, int rs, int rt);
    return {isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic isa_pkg::word_t enc_i(isa_pkg::opcode_t op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic isa_pkg::word_t enc_j(int target);
    return {isa_pkg::OP_J, 26'(target)};
endfunction

// Walks prog from word 0 to HALT, updates ref_regs and appends the expected writebacks
task automatic run_reference();
    isa_pkg::word_t pc;
    isa_pkg::word_t nxt;
    isa_pkg::word_t ins;
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t sx;
    isa_pkg::word_t res;
    int dst;
    bit wr;
    bit done;
    pc   = '0;
    done = 1'b0;
    for (int steps = 0; steps < 50 * IMEM_DEPTH && !done; steps++) begin
        ins = prog[int'(pc % IMEM_DEPTH)];
        a   = ref_regs[ins[25:21]];
        b   = ref_regs[ins[20:16]];
        sx  = {{16{ins[15]}}, ins[15:0]};
        res = '0;
        dst = ins[20:16];
        wr  = 1'b1;
        nxt = pc + 1;
        case (ins[31:26])
            isa_pkg::OP_RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    isa_pkg::FN_ADDU: res = a + b;
                    isa_pkg::FN_SUBU: res = a - b;
                    isa_pkg::FN_AND:  res = a & b;
                    isa_pkg::FN_OR:   res = a | b;
                    isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          wr = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: res = a + sx;
            isa_pkg::OP_ORI:   res = a | {16'h0000, ins[15:0]};
            isa_pkg::OP_LUI:   res = {ins[15:0], 16'h0000};
            isa_pkg::OP_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    nxt = pc + 1 + sx;
                end
            end
            isa_pkg::OP_BNE: begin
                wr = 1'b0;
                if (a != b) begin
                    nxt = pc + 1 + sx;
                end
            end
            isa_pkg::OP_J: begin
                wr  = 1'b0;
                nxt = {nxt[31:26], ins[25:0]}; // Word target within the current region
            end
            isa_pkg::OP_HALT: begin
                wr   = 1'b0;
                done = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 0) begin
            ref_regs[dst]        = res;
            exp_reg[exp_count]  = 5'(dst);
            exp_data[exp_count] = res;
            exp_count++;
        end
        pc = nxt;
    end
endtask

//--- testbench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int IMEM_DEPTH      = 64;
    localparam int MAX_WB          = 256;
    localparam int N_TESTS         = 5;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TESTS * IMEM_DEPTH * 50;

    logic               clk_to_use;
    logic               i_rst;
    logic               i_imem_we;
    isa_pkg::word_t     i_imem_addr;
    isa_pkg::word_t     i_imem_data;
    logic               i_start;
    isa_pkg::reg_addr_t i_dbg_addr;
    logic               o_wb_valid;
    isa_pkg::reg_addr_t o_wb_reg;
    isa_pkg::word_t     o_wb_data;
    logic               o_halted;
    isa_pkg::word_t     o_dbg_data;

    isa_pkg::word_t     prog [IMEM_DEPTH];
    isa_pkg::word_t     ref_regs [32];       // Reference register state
    isa_pkg::reg_addr_t exp_reg [MAX_WB];
    isa_pkg::word_t     exp_data [MAX_WB];
    int                 exp_count = 0;
    int                 wb_idx = 0;          // Writebacks seen so far
    logic               started = 1'b0;
    string              test_name = "none";

    `include "tb_mips_asm.svh"

    mips_core #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) uut (
        .clk_to_use  (clk_to_use),
        .i_rst       (i_rst),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_start     (i_start),
        .i_dbg_addr  (i_dbg_addr),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data),
        .o_halted    (o_halted),
        .o_dbg_data  (o_dbg_data)
    );

    always #4 clk_to_use = ~clk_to_use;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_wb(input int idx, input isa_pkg::reg_addr_t act_reg,
                             input isa_pkg::word_t act_data);
        if (idx >= exp_count) begin
            stop_with_failure($sformatf("%s: unexpected extra writeback of r%0d = %08h",
                test_name, act_reg, act_data));
        end else begin
            stop_with_failure($sformatf(
                "mismatch %s: writeback %0d expected r%0d = %08h, got r%0d = %08h",
                test_name, idx, exp_reg[idx], exp_data[idx], act_reg, act_data));
        end
    endtask

    always @(posedge clk_to_use) begin
        if (!i_rst && o_wb_valid) begin
            wb_idx <= wb_idx + 1;
        end
    end

    a_wb_stream: assert property (
        @(posedge clk_to_use) disable iff (i_rst)
        o_wb_valid |-> (wb_idx < exp_count && o_wb_reg == exp_reg[wb_idx]
                        && o_wb_data == exp_data[wb_idx])
    ) else report_wb($sampled(wb_idx), $sampled(o_wb_reg), $sampled(o_wb_data));

    a_quiet_before_start: assert property (
        @(posedge clk_to_use) disable iff (i_rst) !started |-> (!o_wb_valid && !o_halted)
    ) else stop_with_failure("writeback or halt seen before the first start");

    a_no_wb_when_halted: assert property (
        @(posedge clk_to_use) disable iff (i_rst) o_halted |-> !o_wb_valid
    ) else stop_with_failure("writeback reported while the core is halted");

    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk_to_use);
            i_dbg_addr = 5'(r);
            @(posedge clk_to_use);
            assert (o_dbg_data == ref_regs[r]) else
                stop_with_failure($sformatf("mismatch %s: r%0d expected %08h, got %08h",
                    test_name, r, ref_regs[r], o_dbg_data));
        end
    endtask

    // Pads, loads and runs prog, then compares the stream length and all registers
    task automatic run_program(input string name, input int len);
        test_name = name;
        for (int a = len; a < IMEM_DEPTH; a++) begin
            prog[a] = enc_i(isa_pkg::OP_HALT, 0, 0, a); // Filler halts tagged with address
        end
        run_reference();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(negedge clk_to_use);
            i_imem_we   = 1'b1;
            i_imem_addr = a;
            i_imem_data = prog[a];
        end
        @(negedge clk_to_use);
        i_imem_we = 1'b0;
        i_start   = 1'b1;
        started   = 1'b1;
        @(negedge clk_to_use);
        i_start = 1'b0;
        do begin
            @(negedge clk_to_use);
        end while (!o_halted);
        assert (wb_idx == exp_count) else
            stop_with_failure($sformatf("mismatch %s: writeback count expected %0d, got %0d",
                test_name, exp_count, wb_idx));
        check_registers();
    endtask

    task automatic test_alu_chain();
        prog[0]  = enc_i(isa_pkg::OP_ADDIU, 1, 0, 16'h1234);
        prog[1]  = enc_i(isa_pkg::OP_LUI, 2, 0, 16'h8001);
        prog[2]  = enc_i(isa_pkg::OP_ORI, 3, 2, 16'hf0f0); // Zero extended
        prog[3]  = enc_r(isa_pkg::FN_ADDU, 4, 3, 1);
        prog[4]  = enc_r(isa_pkg::FN_SUBU, 5, 4, 1);
        prog[5]  = enc_r(isa_pkg::FN_AND, 6, 5, 4);
        prog[6]  = enc_r(isa_pkg::FN_OR, 7, 6, 1);
        prog[7]  = enc_r(isa_pkg::FN_SLT, 8, 7, 1);        // Negative operand
        prog[8]  = enc_r(isa_pkg::FN_SLT, 9, 1, 8);
        prog[9]  = enc_i(isa_pkg::OP_ADDIU, 10, 9, -5);
        prog[10] = enc_r(isa_pkg::FN_ADDU, 10, 10, 10);
        prog[11] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        run_program("alu_chain", 12);
    endtask

    task automatic test_branches();
        prog[0]  = enc_i(isa_pkg::OP_ADDIU, 11, 0, 3);
        prog[1]  = enc_i(isa_pkg::OP_ADDIU, 12, 0, 0);
        prog[2]  = enc_i(isa_pkg::OP_ADDIU, 12, 12, 7);
        prog[3]  = enc_i(isa_pkg::OP_ADDIU, 11, 11, -1);
        prog[4]  = enc_i(isa_pkg::OP_BNE, 0, 11, -3);  // Back to word 2 for three passes
        prog[5]  = enc_i(isa_pkg::OP_BEQ, 0, 11, 1);
        prog[6]  = enc_i(isa_pkg::OP_ADDIU, 13, 0, 16'h66);
        prog[7]  = enc_i(isa_pkg::OP_BEQ, 0, 12, 1);
        prog[8]  = enc_i(isa_pkg::OP_BNE, 12, 12, 1);
        prog[9]  = enc_i(isa_pkg::OP_ADDIU, 14, 12, 1);
        prog[10] = enc_i(isa_pkg::OP_BEQ, 14, 14, 2);
        prog[11] = enc_i(isa_pkg::OP_ADDIU, 13, 0, 16'h77);
        prog[12] = enc_i(isa_pkg::OP_ADDIU, 13, 0, 16'h88);
        prog[13] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        run_program("branches", 14);
    endtask

    task automatic test_jump();
        prog[0] = enc_i(isa_pkg::OP_ADDIU, 15, 0, 1);
        prog[1] = enc_j(4);
        prog[2] = enc_i(isa_pkg::OP_ADDIU, 15, 0, 16'h22);
        prog[3] = enc_i(isa_pkg::OP_ADDIU, 16, 0, 16'h33);
        prog[4] = enc_i(isa_pkg::OP_ADDIU, 16, 15, 5);
        prog[5] = enc_j(7);
        prog[6] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        prog[7] = enc_r(isa_pkg::FN_ADDU, 17, 16, 15);
        prog[8] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        run_program("jump", 9);
    endtask

    task automatic test_halt_r0();
        prog[0] = enc_i(isa_pkg::OP_ADDIU, 0, 0, 16'h55);
        prog[1] = enc_r(isa_pkg::FN_ADDU, 0, 1, 2);
        prog[2] = enc_i(isa_pkg::OP_ADDIU, 18, 0, 9);   // Must see r0 as zero
        prog[3] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        prog[4] = enc_i(isa_pkg::OP_ADDIU, 19, 0, 1);
        prog[5] = enc_i(isa_pkg::OP_ADDIU, 20, 0, 2);
        run_program("halt_r0", 6);
    endtask

    task automatic test_reload();
        logic [15:0] rnd [4];
        for (int i = 0; i < 4; i++) begin
            rnd[i] = 16'($urandom);
        end
        prog[0]  = enc_i(isa_pkg::OP_ADDIU, 21, 0, rnd[0]);
        prog[1]  = enc_i(isa_pkg::OP_ORI, 22, 21, rnd[1]);
        prog[2]  = enc_i(isa_pkg::OP_LUI, 23, 0, rnd[2]);
        prog[3]  = enc_r(isa_pkg::FN_ADDU, 24, 22, 23);
        prog[4]  = enc_r(isa_pkg::FN_SUBU, 25, 24, 10); // r10 left by an earlier program
        prog[5]  = enc_r(isa_pkg::FN_SLT, 26, 25, 24);
        prog[6]  = enc_i(isa_pkg::OP_BEQ, 0, 26, 1);
        prog[7]  = enc_i(isa_pkg::OP_ADDIU, 27, 26, rnd[3]);
        prog[8]  = enc_r(isa_pkg::FN_AND, 28, 24, 1);
        prog[9]  = enc_r(isa_pkg::FN_OR, 29, 28, 25);
        prog[10] = enc_i(isa_pkg::OP_HALT, 0, 0, 0);
        run_program("reload", 11);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_to_use);
        stop_with_failure("timeout: the core never reached halt within the cycle budget");
    end

    initial begin
        void'($urandom(32'hd5e));
        clk_to_use  = 1'b0;
        i_rst       = 1'b1;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        i_start     = 1'b0;
        i_dbg_addr  = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_to_use);
        @(negedge clk_to_use);
        i_rst = 1'b0;

        test_name = "after_reset";
        check_registers();
        test_alu_chain();
        test_branches();
        test_jump();
        test_halt_r0();
        test_reload();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- mips_core.f
+incdir+testbench
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/mips_control.sv
hdl/mips_fetch.sv
hdl/mips_regfile.sv
hdl/mips_execute.sv
hdl/mips_core.sv
testbench/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - hdl/isa_pkg.sv
  - hdl/ctrl_pkg.sv
  - hdl/mips_control.sv
  - hdl/mips_fetch.sv
  - hdl/mips_regfile.sv
  - hdl/mips_execute.sv
  - hdl/mips_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mips_core.sv
